/* Makefile */
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module rvCoreTb -Mdir obj_dir -f compile.f

run: compile
	./obj_dir/VrvCoreTb > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TEST FAILED" sim.log; then exit 1; fi
	@grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* compile.f */
logic/rvPkg.sv
logic/instrFetch.sv
logic/instrDecode.sv
logic/executeUnit.sv
logic/regFile.sv
logic/loadStore.sv
logic/busArbiter.sv
logic/rvCore.sv
testbench/memModel.sv
testbench/rvCore_asserts.sv
testbench/rvCoreTb.sv

/* logic/busArbiter.sv */
`timescale 1ns/1ps

module busArbiter (
   input  logic                   clk,
   input  logic                   rstn,
   input  logic                   fetchValid,
   input  logic [rvPkg::xlen-1:0] fetchAddr,
   output logic                   fetchReady,
   input  logic                   lsValid,
   input  logic [rvPkg::xlen-1:0] lsAddr,
   input  logic                   lsWrite,
   input  logic [rvPkg::xlen-1:0] lsWData,
   output logic                   lsReady,
   output logic                   memValid,
   output logic [rvPkg::xlen-1:0] memAddr,
   output logic                   memWrite,
   output logic [rvPkg::xlen-1:0] memWData,
   input  logic                   memReady
);

   logic grantFetch;
   logic grantLs;
   logic busHeld;
   logic ownFetch;
   logic ownLs;

   assign busHeld = grantFetch || grantLs;

   // a held grant sticks; a free bus goes to load/store first
   assign ownLs = grantLs || (!busHeld && lsValid);
   assign ownFetch = grantFetch || (!busHeld && !lsValid && fetchValid);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         grantFetch <= 1'b0;
         grantLs <= 1'b0;
      end
      else begin
         grantFetch <= ownFetch && !memReady;
         grantLs <= ownLs && !memReady;
      end
   end

   assign memValid = (ownLs && lsValid) || (ownFetch && fetchValid);
   assign memAddr = ownLs ? lsAddr : fetchAddr;
   assign memWrite = ownLs && lsWrite;
   assign memWData = lsWData; // only fetch reads, so no mux

   assign lsReady = ownLs && memReady;
   assign fetchReady = ownFetch && memReady;

endmodule

/* logic/executeUnit.sv */
`timescale 1ns/1ps

module executeUnit (
   input  rvPkg::instrClassT         instrClass,
   input  rvPkg::aluOpT              aluOp,
   input  logic [rvPkg::regIdxW-1:0] rd,
   input  logic [rvPkg::xlen-1:0]    imm,
   input  logic [rvPkg::xlen-1:0]    rs1Data,
   input  logic [rvPkg::xlen-1:0]    rs2Data,
   input  logic                      irTake,
   output logic                      wrEn,
   output logic [rvPkg::regIdxW-1:0] wrIdx,
   output logic [rvPkg::xlen-1:0]    wrData
);

   logic [rvPkg::xlen-1:0] opB;
   logic [4:0]             shamt;
   logic [rvPkg::xlen-1:0] result;

   // I-type and LUI read x0 as rs2 and R-type carries a zero imm,
   // so OR-ing the two picks whichever operand is live
   assign opB = rs2Data | imm;
   assign shamt = opB[4:0];

   always_comb begin
      case (aluOp)
         rvPkg::aluAdd: result = rs1Data + opB;
         rvPkg::aluSub: result = rs1Data - opB; // wraps
         rvPkg::aluXor: result = rs1Data ^ opB;
         rvPkg::aluOr: result = rs1Data | opB;
         rvPkg::aluAnd: result = rs1Data & opB;
         rvPkg::aluSlt: begin
            result = ($signed(rs1Data) < $signed(opB)) ? 32'd1 : 32'd0;
         end
         rvPkg::aluSltu: begin
            result = (rs1Data < opB) ? 32'd1 : 32'd0;
         end
         rvPkg::aluSll: result = rs1Data << shamt;
         rvPkg::aluSrl: result = rs1Data >> shamt;
         rvPkg::aluSra: result = $signed(rs1Data) >>> shamt;
         rvPkg::aluPass: result = opB;
         default: result = '0;
      endcase
   end

   // register write lands at the edge the instruction leaves decode
   assign wrEn = irTake && (instrClass == rvPkg::clsAlu);
   assign wrIdx = rd;
   assign wrData = result;

endmodule

/* logic/instrDecode.sv */
`timescale 1ns/1ps

module instrDecode (
   input  logic                      irValid,
   input  logic [rvPkg::xlen-1:0]    irWord,
   output logic                      irTake,
   input  logic                      lsBusy,
   output rvPkg::instrClassT         instrClass,
   output rvPkg::aluOpT              aluOp,
   output logic [rvPkg::regIdxW-1:0] rd,
   output logic [rvPkg::regIdxW-1:0] rs1,
   output logic [rvPkg::regIdxW-1:0] rs2,
   output logic [rvPkg::xlen-1:0]    imm,
   output logic                      haltReq
);

   logic [6:0]             opcode;
   logic [2:0]             funct3;
   logic [6:0]             funct7;
   logic [rvPkg::xlen-1:0] immI;
   logic [rvPkg::xlen-1:0] immS;
   logic [rvPkg::xlen-1:0] immU;
   logic [rvPkg::xlen-1:0] shamt;

   assign opcode = irWord[6:0];
   assign funct3 = irWord[14:12];
   assign funct7 = irWord[31:25];

   assign immI = {{20{irWord[31]}}, irWord[31:20]};
   assign immS = {{20{irWord[31]}}, irWord[31:25], irWord[11:7]};
   assign immU = {irWord[31:12], 12'b0};
   assign shamt = {27'b0, irWord[24:20]};

   // stall only behind an outstanding memory op
   assign irTake = irValid && !lsBusy;

   assign haltReq = (instrClass == rvPkg::clsHalt) || (instrClass == rvPkg::clsIllegal);

   always_comb begin
      instrClass = rvPkg::clsNone;
      aluOp = rvPkg::aluAdd;
      rd = irWord[11:7];
      rs1 = irWord[19:15];
      rs2 = '0; // x0 unless R-type or store
      imm = '0;
      if (irValid) begin
         case (opcode)
            rvPkg::opcOp: begin
               instrClass = rvPkg::clsAlu;
               rs2 = irWord[24:20];
               if (funct7 == 7'b0000000) begin
                  case (funct3)
                     3'b000: aluOp = rvPkg::aluAdd;
                     3'b100: aluOp = rvPkg::aluXor;
                     3'b110: aluOp = rvPkg::aluOr;
                     3'b111: aluOp = rvPkg::aluAnd;
                     3'b010: aluOp = rvPkg::aluSlt;
                     3'b011: aluOp = rvPkg::aluSltu;
                     3'b001: aluOp = rvPkg::aluSll;
                     default: instrClass = rvPkg::clsIllegal; // SRL/SRA not kept
                  endcase
               end
               else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                  aluOp = rvPkg::aluSub;
               end
               else begin
                  instrClass = rvPkg::clsIllegal;
               end
            end
            rvPkg::opcOpImm: begin
               instrClass = rvPkg::clsAlu;
               imm = immI;
               case (funct3)
                  3'b000: aluOp = rvPkg::aluAdd;
                  3'b100: aluOp = rvPkg::aluXor;
                  3'b110: aluOp = rvPkg::aluOr;
                  3'b111: aluOp = rvPkg::aluAnd;
                  3'b010: aluOp = rvPkg::aluSlt;
                  3'b011: aluOp = rvPkg::aluSltu;
                  3'b001: begin
                     aluOp = rvPkg::aluSll;
                     imm = shamt;
                     if (funct7 != 7'b0000000) begin
                        instrClass = rvPkg::clsIllegal;
                     end
                  end
                  default: begin // 101, right shifts
                     imm = shamt;
                     if (funct7 == 7'b0000000) begin
                        aluOp = rvPkg::aluSrl;
                     end
                     else if (funct7 == 7'b0100000) begin
                        aluOp = rvPkg::aluSra;
                     end
                     else begin
                        instrClass = rvPkg::clsIllegal;
                     end
                  end
               endcase
            end
            rvPkg::opcLui: begin
               instrClass = rvPkg::clsAlu;
               aluOp = rvPkg::aluPass;
               imm = immU;
            end
            rvPkg::opcLoad: begin
               imm = immI;
               instrClass = (funct3 == 3'b010) ? rvPkg::clsLoad : rvPkg::clsIllegal;
            end
            rvPkg::opcStore: begin
               imm = immS;
               rs2 = irWord[24:20]; // store data
               instrClass = (funct3 == 3'b010) ? rvPkg::clsStore : rvPkg::clsIllegal;
            end
            rvPkg::opcHalt: instrClass = rvPkg::clsHalt;
            default: instrClass = rvPkg::clsIllegal;
         endcase
      end
   end

endmodule

/* logic/instrFetch.sv */
`timescale 1ns/1ps

module instrFetch (
   input  logic                   clk,
   input  logic                   rstn,
   input  logic                   start,
   input  logic                   haltReq,
   output logic                   fetchValid,
   output logic [rvPkg::xlen-1:0] fetchAddr,
   input  logic                   fetchReady,
   input  logic [rvPkg::xlen-1:0] memRData,
   output logic                   irValid,
   output logic [rvPkg::xlen-1:0] irWord,
   input  logic                   irTake,
   output logic                   halted
);

   logic [rvPkg::xlen-1:0] pc; // word address
   logic                   fetchXfer;

   assign fetchAddr = pc;

   // room in the IR, but never behind a halting word
   assign fetchValid = !halted && (!irValid || (irTake && !haltReq));
   assign fetchXfer = fetchValid && fetchReady;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         halted <= 1'b1;
      end
      else if (start) begin
         halted <= 1'b0;
      end
      else if (haltReq && irTake) begin
         halted <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         pc <= '0;
      end
      else if (start) begin
         pc <= '0;
      end
      else if (fetchXfer) begin
         pc <= pc + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         irValid <= 1'b0;
      end
      else if (fetchXfer) begin
         irValid <= 1'b1; // refill wins over take
      end
      else if (irTake) begin
         irValid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (fetchXfer) begin
         irWord <= memRData;
      end
   end

endmodule

/* logic/loadStore.sv */
`timescale 1ns/1ps

module loadStore (
   input  logic                      clk,
   input  logic                      rstn,
   input  rvPkg::instrClassT         instrClass,
   input  logic [rvPkg::regIdxW-1:0] rd,
   input  logic [rvPkg::xlen-1:0]    imm,
   input  logic                      irTake,
   input  logic [rvPkg::xlen-1:0]    rs1Data,
   input  logic [rvPkg::xlen-1:0]    rs2Data,
   output logic                      lsValid,
   output logic [rvPkg::xlen-1:0]    lsAddr,
   output logic                      lsWrite,
   output logic [rvPkg::xlen-1:0]    lsWData,
   input  logic                      lsReady,
   input  logic [rvPkg::xlen-1:0]    memRData,
   output logic                      lsBusy,
   output logic                      wrEn,
   output logic [rvPkg::regIdxW-1:0] wrIdx,
   output logic [rvPkg::xlen-1:0]    wrData
);

   logic                      capture;
   logic [rvPkg::regIdxW-1:0] rdQ;

   assign capture = irTake &&
                    (instrClass == rvPkg::clsLoad || instrClass == rvPkg::clsStore);

   // request starts the cycle after capture and holds until accepted
   assign lsValid = lsBusy;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         lsBusy <= 1'b0;
      end
      else if (capture) begin
         lsBusy <= 1'b1;
      end
      else if (lsValid && lsReady) begin
         lsBusy <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (capture) begin
         lsAddr <= rs1Data + imm; // word address, no scaling
         lsWData <= rs2Data;
         lsWrite <= (instrClass == rvPkg::clsStore);
         rdQ <= rd;
      end
   end

   // read data is valid in the transfer cycle itself
   assign wrEn = lsBusy && !lsWrite && lsReady;
   assign wrIdx = rdQ;
   assign wrData = memRData;

endmodule

/* logic/regFile.sv */
`timescale 1ns/1ps

module regFile (
   input  logic                      clk,
   input  logic                      rstn,
   input  logic [rvPkg::regIdxW-1:0] rs1,
   input  logic [rvPkg::regIdxW-1:0] rs2,
   output logic [rvPkg::xlen-1:0]    rs1Data,
   output logic [rvPkg::xlen-1:0]    rs2Data,
   input  logic                      aluWrEn,
   input  logic [rvPkg::regIdxW-1:0] aluWrIdx,
   input  logic [rvPkg::xlen-1:0]    aluWrData,
   input  logic                      lsWrEn,
   input  logic [rvPkg::regIdxW-1:0] lsWrIdx,
   input  logic [rvPkg::xlen-1:0]    lsWrData
);

   logic [rvPkg::xlen-1:0] regs [1:31]; // x0 has no storage

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end
      else if (lsWrEn && lsWrIdx != '0) begin
         regs[lsWrIdx] <= lsWrData; // load data first
      end
      else if (aluWrEn && aluWrIdx != '0) begin
         regs[aluWrIdx] <= aluWrData;
      end
   end

   assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
   assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* logic/rvCore.sv */
`timescale 1ns/1ps

module rvCore (
   input  logic                   clk,
   input  logic                   rstn,
   input  logic                   start,
   output logic                   memValid,
   output logic [rvPkg::xlen-1:0] memAddr,
   output logic                   memWrite,
   output logic [rvPkg::xlen-1:0] memWData,
   input  logic                   memReady,
   input  logic [rvPkg::xlen-1:0] memRData,
   output logic                   halted
);

   logic                      fetchValid;
   logic [rvPkg::xlen-1:0]    fetchAddr;
   logic                      fetchReady;
   logic                      irValid;
   logic [rvPkg::xlen-1:0]    irWord;
   logic                      irTake;
   logic                      haltReq;
   rvPkg::instrClassT         instrClass;
   rvPkg::aluOpT              aluOp;
   logic [rvPkg::regIdxW-1:0] rd;
   logic [rvPkg::regIdxW-1:0] rs1;
   logic [rvPkg::regIdxW-1:0] rs2;
   logic [rvPkg::xlen-1:0]    imm;
   logic [rvPkg::xlen-1:0]    rs1Data;
   logic [rvPkg::xlen-1:0]    rs2Data;
   logic                      aluWrEn;
   logic [rvPkg::regIdxW-1:0] aluWrIdx;
   logic [rvPkg::xlen-1:0]    aluWrData;
   logic                      lsWrEn;
   logic [rvPkg::regIdxW-1:0] lsWrIdx;
   logic [rvPkg::xlen-1:0]    lsWrData;
   logic                      lsValid;
   logic [rvPkg::xlen-1:0]    lsAddr;
   logic                      lsWrite;
   logic [rvPkg::xlen-1:0]    lsWData;
   logic                      lsReady;
   logic                      lsBusy;

   instrFetch instrFetch_i (
      .clk        (clk),
      .rstn       (rstn),
      .start      (start),
      .haltReq    (haltReq),
      .fetchValid (fetchValid),
      .fetchAddr  (fetchAddr),
      .fetchReady (fetchReady),
      .memRData   (memRData),
      .irValid    (irValid),
      .irWord     (irWord),
      .irTake     (irTake),
      .halted     (halted)
   );

   instrDecode instrDecode_i (
      .irValid    (irValid),
      .irWord     (irWord),
      .irTake     (irTake),
      .lsBusy     (lsBusy),
      .instrClass (instrClass),
      .aluOp      (aluOp),
      .rd         (rd),
      .rs1        (rs1),
      .rs2        (rs2),
      .imm        (imm),
      .haltReq    (haltReq)
   );

   executeUnit executeUnit_i (
      .instrClass (instrClass),
      .aluOp      (aluOp),
      .rd         (rd),
      .imm        (imm),
      .rs1Data    (rs1Data),
      .rs2Data    (rs2Data),
      .irTake     (irTake),
      .wrEn       (aluWrEn),
      .wrIdx      (aluWrIdx),
      .wrData     (aluWrData)
   );

   regFile regFile_i (
      .clk       (clk),
      .rstn      (rstn),
      .rs1       (rs1),
      .rs2       (rs2),
      .rs1Data   (rs1Data),
      .rs2Data   (rs2Data),
      .aluWrEn   (aluWrEn),
      .aluWrIdx  (aluWrIdx),
      .aluWrData (aluWrData),
      .lsWrEn    (lsWrEn),
      .lsWrIdx   (lsWrIdx),
      .lsWrData  (lsWrData)
   );

   loadStore loadStore_i (
      .clk        (clk),
      .rstn       (rstn),
      .instrClass (instrClass),
      .rd         (rd),
      .imm        (imm),
      .irTake     (irTake),
      .rs1Data    (rs1Data),
      .rs2Data    (rs2Data),
      .lsValid    (lsValid),
      .lsAddr     (lsAddr),
      .lsWrite    (lsWrite),
      .lsWData    (lsWData),
      .lsReady    (lsReady),
      .memRData   (memRData),
      .lsBusy     (lsBusy),
      .wrEn       (lsWrEn),
      .wrIdx      (lsWrIdx),
      .wrData     (lsWrData)
   );

   busArbiter busArbiter_i (
      .clk        (clk),
      .rstn       (rstn),
      .fetchValid (fetchValid),
      .fetchAddr  (fetchAddr),
      .fetchReady (fetchReady),
      .lsValid    (lsValid),
      .lsAddr     (lsAddr),
      .lsWrite    (lsWrite),
      .lsWData    (lsWData),
      .lsReady    (lsReady),
      .memValid   (memValid),
      .memAddr    (memAddr),
      .memWrite   (memWrite),
      .memWData   (memWData),
      .memReady   (memReady)
   );

endmodule

/* logic/rvPkg.sv */
package rvPkg;

   localparam int xlen = 32;
   localparam int regIdxW = 5;

   // major opcodes
   localparam logic [6:0] opcOp = 7'b0110011;
   localparam logic [6:0] opcOpImm = 7'b0010011;
   localparam logic [6:0] opcLui = 7'b0110111;
   localparam logic [6:0] opcLoad = 7'b0000011;
   localparam logic [6:0] opcStore = 7'b0100011;
   localparam logic [6:0] opcHalt = 7'b1111111; // stops the core

   typedef enum logic [3:0] {
      aluAdd,
      aluSub,
      aluXor,
      aluOr,
      aluAnd,
      aluSlt,
      aluSltu,
      aluSll,
      aluSrl,
      aluSra,
      aluPass // LUI result straight from imm
   } aluOpT;

   typedef enum logic [2:0] {
      clsNone,
      clsAlu,
      clsLoad,
      clsStore,
      clsHalt,
      clsIllegal
   } instrClassT;

endpackage

/* testbench/memModel.sv */
`timescale 1ns/1ps

module memModel (
   input  logic                   clk,
   input  logic                   stallOn,
   input  logic                   memValid,
   input  logic [rvPkg::xlen-1:0] memAddr,
   input  logic                   memWrite,
   input  logic [rvPkg::xlen-1:0] memWData,
   output logic                   memReady,
   output logic [rvPkg::xlen-1:0] memRData
);

   logic [rvPkg::xlen-1:0] mem [0:255]; // 256 words, low address bits only
   logic                   readyQ = 1'b0;

   assign memReady = readyQ;
   assign memRData = mem[memAddr[7:0]]; // read data in the transfer cycle

   // ready changes a little after each edge
   always @(posedge clk) begin
      #1;
      readyQ <= stallOn ? (($urandom % 4) != 0) : 1'b1;
   end

   always @(posedge clk) begin
      if (memValid && memReady && memWrite) begin
         mem[memAddr[7:0]] <= memWData;
      end
   end

   task automatic loadWord(input int addr, input logic [rvPkg::xlen-1:0] data);
      mem[addr[7:0]] <= data;
   endtask

   function automatic logic [rvPkg::xlen-1:0] readWord(input int addr);
      return mem[addr[7:0]];
   endfunction

endmodule

/* testbench/rvCoreTb.sv */
`timescale 1ns/1ps

module rvCoreTb;

   typedef enum int {
      kAdd, kSub, kXor, kOr, kAnd, kSlt, kSltu, kSll,
      kAddi, kXori, kOri, kAndi, kSlti, kSltiu, kSlli, kSrli, kSrai,
      kLui, kLoad, kZeroReg, kIllegal
   } testKindT;

   logic                   clk = 1'b0;
   logic                   rstn = 1'b0;
   logic                   start = 1'b0;
   logic                   stallOn = 1'b0;
   logic                   memValid;
   logic [rvPkg::xlen-1:0] memAddr;
   logic                   memWrite;
   logic [rvPkg::xlen-1:0] memWData;
   logic                   memReady;
   logic [rvPkg::xlen-1:0] memRData;
   logic                   halted;

   testKindT    kindQ[$];
   logic [31:0] opAQ[$];
   logic [31:0] opBQ[$]; // second operand or immediate
   logic [31:0] expQ[$];
   int          errorCount = 0;
   int          cycleCount = 0;
   int          cycleLimit = 0;

   always #2 clk = ~clk;

   rvCore rvCore_i (
      .clk      (clk),
      .rstn     (rstn),
      .start    (start),
      .memValid (memValid),
      .memAddr  (memAddr),
      .memWrite (memWrite),
      .memWData (memWData),
      .memReady (memReady),
      .memRData (memRData),
      .halted   (halted)
   );

   memModel memModel_i (
      .clk      (clk),
      .stallOn  (stallOn),
      .memValid (memValid),
      .memAddr  (memAddr),
      .memWrite (memWrite),
      .memWData (memWData),
      .memReady (memReady),
      .memRData (memRData)
   );

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
         $display("timeout: the core did not finish within %0d cycles", cycleLimit);
         $display("TEST FAILED");
         $finish;
      end
   end

   task automatic compareWord(input logic [31:0] got, input logic [31:0] want,
                              input string what);
      if (got !== want) begin
         errorCount++;
         $display("MISMATCH at time %0t: %s, got %h, expected %h", $time, what, got, want);
      end
   endtask

   function automatic int storeAddr(input int row);
      return 200 + row;
   endfunction

   function automatic logic [31:0] fillWord(input int addr);
      return 32'hA5C3_0000 ^ addr;
   endfunction

   function automatic logic [19:0] upperOf(input logic [31:0] v);
      logic [31:0] t;
      t = v + 32'h800; // ADDI adds back a signed low part
      return t[31:12];
   endfunction

   // x3 = x1 op x2
   function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3);
      return {f7, 5'd2, 5'd1, f3, 5'd3, rvPkg::opcOp};
   endfunction

   function automatic logic [31:0] encI(input logic [11:0] imm12, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
      return {imm12, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] encS(input logic [11:0] imm12, input logic [4:0] rs2);
      return {imm12[11:5], rs2, 5'd0, 3'b010, imm12[4:0], rvPkg::opcStore}; // base x0
   endfunction

   function automatic logic [31:0] encU(input logic [19:0] imm20, input logic [4:0] rd);
      return {imm20, rd, rvPkg::opcLui};
   endfunction

   function automatic logic [31:0] opWord(input testKindT kind, input logic [31:0] b);
      case (kind)
         kAdd: return encR(7'h00, 3'b000);
         kSub: return encR(7'h20, 3'b000);
         kXor: return encR(7'h00, 3'b100);
         kOr: return encR(7'h00, 3'b110);
         kAnd: return encR(7'h00, 3'b111);
         kSlt: return encR(7'h00, 3'b010);
         kSltu: return encR(7'h00, 3'b011);
         kSll: return encR(7'h00, 3'b001);
         kAddi: return encI(b[11:0], 5'd1, 3'b000, 5'd3, rvPkg::opcOpImm);
         kXori: return encI(b[11:0], 5'd1, 3'b100, 5'd3, rvPkg::opcOpImm);
         kOri: return encI(b[11:0], 5'd1, 3'b110, 5'd3, rvPkg::opcOpImm);
         kAndi: return encI(b[11:0], 5'd1, 3'b111, 5'd3, rvPkg::opcOpImm);
         kSlti: return encI(b[11:0], 5'd1, 3'b010, 5'd3, rvPkg::opcOpImm);
         kSltiu: return encI(b[11:0], 5'd1, 3'b011, 5'd3, rvPkg::opcOpImm);
         kSlli: return encI({7'h00, b[4:0]}, 5'd1, 3'b001, 5'd3, rvPkg::opcOpImm);
         kSrli: return encI({7'h00, b[4:0]}, 5'd1, 3'b101, 5'd3, rvPkg::opcOpImm);
         kSrai: return encI({7'h20, b[4:0]}, 5'd1, 3'b101, 5'd3, rvPkg::opcOpImm);
         kLui: return encU(b[19:0], 5'd3);
         kLoad: return encI(b[11:0], 5'd1, 3'b010, 5'd3, rvPkg::opcLoad); // LW x3, b(x1)
         kZeroReg: return encI(b[11:0], 5'd1, 3'b000, 5'd0, rvPkg::opcOpImm);
         default: return encR(7'h00, 3'b101); // SRL, outside the kept set
      endcase
   endfunction

   task automatic addRow(input testKindT kind, input logic [31:0] a, input logic [31:0] b,
                         input logic [31:0] exp);
      kindQ.push_back(kind);
      opAQ.push_back(a);
      opBQ.push_back(b);
      expQ.push_back(exp);
   endtask

   task automatic buildTable();
      addRow(kAdd, 32'h7FFF_FFFF, 32'h0000_0001, 32'h8000_0000);
      addRow(kSub, 32'h0000_0005, 32'h0000_0007, 32'hFFFF_FFFE); // wraps
      addRow(kXor, 32'hF0F0_F0F0, 32'h0FF0_0FF0, 32'hFF00_FF00);
      addRow(kOr, 32'h1234_0000, 32'h0000_5678, 32'h1234_5678);
      addRow(kAnd, 32'hFFFF_00FF, 32'h0F0F_0F0F, 32'h0F0F_000F);
      addRow(kSlt, 32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0001); // -1 < 1
      addRow(kSltu, 32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0000);
      addRow(kSll, 32'h0000_0003, 32'h0000_0021, 32'h0000_0006); // low 5 bits only
      addRow(kAddi, 32'h0000_000A, 32'hFFFF_FFFD, 32'h0000_0007);
      addRow(kXori, 32'h0000_FFFF, 32'hFFFF_FFFF, 32'hFFFF_0000);
      addRow(kOri, 32'h8000_0000, 32'h0000_07FF, 32'h8000_07FF);
      addRow(kAndi, 32'h1234_5678, 32'hFFFF_FFF0, 32'h1234_5670);
      addRow(kSlti, 32'hFFFF_FF00, 32'hFFFF_FF01, 32'h0000_0001);
      addRow(kSltiu, 32'h0000_0005, 32'hFFFF_FFFF, 32'h0000_0001);
      addRow(kSlli, 32'h0000_0001, 32'h0000_001F, 32'h8000_0000);
      addRow(kSrli, 32'h8000_0000, 32'h0000_0004, 32'h0800_0000);
      addRow(kSrai, 32'h8000_0000, 32'h0000_0004, 32'hF800_0000);
      addRow(kLui, 32'h0000_0000, 32'h000A_BCDE, 32'hABCD_E000);
      addRow(kLoad, 32'h0000_0064, 32'h0000_0032, 32'hCAFE_F00D); // word at 150
      addRow(kZeroReg, 32'h0000_1234, 32'h0000_0005, 32'h0000_0000);
      // store never issues, so the target keeps its fill
      addRow(kIllegal, 32'h0000_0040, 32'h0000_0003, fillWord(storeAddr(kindQ.size())));
   endtask

   task automatic loadProgram(input int row);
      logic [31:0] a;
      logic [31:0] b;
      logic [4:0]  srcReg;
      a = opAQ[row];
      b = opBQ[row];
      srcReg = (kindQ[row] == kZeroReg) ? 5'd0 : 5'd3;
      for (int i = 0; i < 256; i++) begin
         memModel_i.loadWord(i, fillWord(i));
      end
      memModel_i.loadWord(0, encU(upperOf(a), 5'd1));
      memModel_i.loadWord(1, encI(a[11:0], 5'd1, 3'b000, 5'd1, rvPkg::opcOpImm));
      memModel_i.loadWord(2, encU(upperOf(b), 5'd2));
      memModel_i.loadWord(3, encI(b[11:0], 5'd2, 3'b000, 5'd2, rvPkg::opcOpImm));
      memModel_i.loadWord(4, opWord(kindQ[row], b));
      memModel_i.loadWord(5, encS(12'(storeAddr(row)), srcReg));
      memModel_i.loadWord(6, 32'hFFFF_FFFF); // halt word
      if (kindQ[row] == kLoad) begin
         memModel_i.loadWord(a + b, expQ[row]);
      end
   endtask

   task automatic runRow(input int row, input int pass);
      string tag;
      tag = $sformatf("pass %0d row %0d", pass, row);
      stallOn = (pass == 1); // set away from the edge the ready model updates on
      @(posedge clk);
      #1;
      rstn = 1'b0;
      loadProgram(row);
      repeat (4) @(posedge clk);
      #1;
      rstn = 1'b1;
      @(posedge clk);
      #1;
      start = 1'b1;
      @(posedge clk);
      #1;
      start = 1'b0;
      @(negedge clk);
      while (!halted) begin
         @(negedge clk);
      end
      repeat (8) begin // bus stays idle once halted
         @(negedge clk);
         compareWord({31'b0, memValid}, 32'd0, {tag, " bus request after halt"});
      end
      compareWord(memModel_i.readWord(storeAddr(row)), expQ[row], {tag, " stored word"});
   endtask

   initial begin
      void'($urandom(23768));
      buildTable();
      cycleLimit = 400 * kindQ.size() * 2;
      // second pass repeats the table under random memReady stalls
      for (int pass = 0; pass < 2; pass++) begin
         for (int row = 0; row < kindQ.size(); row++) begin
            runRow(row, pass);
         end
      end
      $display("all rows run, %0d errors", errorCount);
      if (errorCount == 0) begin
         $display("TEST PASSED");
      end
      else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* testbench/rvCore_asserts.sv */
`timescale 1ns/1ps

module rvCore_asserts (
   input logic                   clk,
   input logic                   rstn,
   input logic                   halted,
   input logic                   fetchReady,
   input logic                   lsReady,
   input logic                   memValid,
   input logic [rvPkg::xlen-1:0] memAddr,
   input logic                   memWrite,
   input logic [rvPkg::xlen-1:0] memWData,
   input logic                   memReady
);

   // a stalled request keeps address and direction
   holdRequestA: assert property (@(posedge clk) disable iff (!rstn)
      memValid && !memReady |=> memValid && $stable(memAddr) && $stable(memWrite))
      else $error("bus request changed before memReady");

   holdWDataA: assert property (@(posedge clk) disable iff (!rstn)
      memValid && memWrite && !memReady |=> $stable(memWData))
      else $error("store data changed before memReady");

   oneGrantA: assert property (@(posedge clk) disable iff (!rstn)
      $onehot0({fetchReady, lsReady}))
      else $error("both peers granted at once");

   // pending load/store drains before the halt word is taken
   haltQuietA: assert property (@(posedge clk) disable iff (!rstn)
      halted |-> !memValid)
      else $error("memory request while halted");

endmodule

bind rvCore rvCore_asserts rvCoreChecks_i (
   .clk        (clk),
   .rstn       (rstn),
   .halted     (halted),
   .fetchReady (fetchReady),
   .lsReady    (lsReady),
   .memValid   (memValid),
   .memAddr    (memAddr),
   .memWrite   (memWrite),
   .memWData   (memWData),
   .memReady   (memReady)
);
